/* logic/stripe_defs.svh */
`ifndef STRIPE_DEFS_SVH
`define STRIPE_DEFS_SVH

// Number of banks as a power of two
`define STRIPE_NUM_BANKS 2

// Host byte address width
`define STRIPE_ADDR_W 8

`define STRIPE_DATA_W 16

`define STRIPE_ID_W 4

// Byte lanes per word
`define STRIPE_STRB_W (`STRIPE_DATA_W / 8)

// AxSIZE value for a full-width transfer
`define STRIPE_FULL_SIZE $clog2(`STRIPE_STRB_W)

// Word index over the whole host space
`define STRIPE_WORD_W (`STRIPE_ADDR_W - $clog2(`STRIPE_STRB_W))

// Low word index bits pick the bank
`define STRIPE_SEL_W $clog2(`STRIPE_NUM_BANKS)

`define STRIPE_BANK_AW (`STRIPE_WORD_W - `STRIPE_SEL_W)

`endif

/* logic/axi_pkg.sv */
package axi_pkg;

  // AxBURST encodings
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // The two xRESP codes this slave returns
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // AxLEN, beats minus one
  typedef logic [7:0] len_t;

endpackage

/* logic/stripe_pkg.sv */
package stripe_pkg;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_REQ,
    RD_WAIT,
    RD_RESP
  } rd_state_e;

  // Last winner at a bank arbiter
  typedef enum logic {
    WR_CLIENT = 1'b0,
    RD_CLIENT = 1'b1
  } client_e;

endpackage

/* logic/bank_if.sv */
`timescale 1ns/1ps

`include "stripe_defs.svh"

interface bank_if;
  logic                       req_valid;
  logic                       req_write;
  logic [`STRIPE_BANK_AW-1:0] req_addr;
  logic [ `STRIPE_DATA_W-1:0] req_data;
  logic [ `STRIPE_STRB_W-1:0] req_strb;
  logic                       req_ready;

  // Read data, one cycle after the read is accepted
  logic                       rsp_valid;
  logic [ `STRIPE_DATA_W-1:0] rsp_data;

  modport client (
    output req_valid, req_write, req_addr, req_data, req_strb,
    input  req_ready, rsp_valid, rsp_data
  );

  modport bank (
    input  req_valid, req_write, req_addr, req_data, req_strb,
    output req_ready, rsp_valid, rsp_data
  );
endinterface

/* logic/stripe_wr.sv */
`timescale 1ns/1ps

`include "stripe_defs.svh"

module stripe_wr (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     awvalid,
  output logic                     awready,
  input  logic [  `STRIPE_ID_W-1:0] awid,
  input  logic [`STRIPE_ADDR_W-1:0] awaddr,
  input  axi_pkg::len_t            awlen,
  input  logic [               2:0] awsize,
  input  axi_pkg::burst_e          awburst,

  input  logic                     wvalid,
  output logic                     wready,
  input  logic [`STRIPE_DATA_W-1:0] wdata,
  input  logic [`STRIPE_STRB_W-1:0] wstrb,
  input  logic                     wlast,

  output logic                     bvalid,
  input  logic                     bready,
  output logic [  `STRIPE_ID_W-1:0] bid,
  output axi_pkg::resp_e           bresp,

  bank_if.client                   wr_bank [`STRIPE_NUM_BANKS]
);
  import axi_pkg::*;
  import stripe_pkg::*;

  localparam int NUM_BANKS = `STRIPE_NUM_BANKS;
  localparam int ADDR_W    = `STRIPE_ADDR_W;
  localparam int WORD_W    = `STRIPE_WORD_W;
  localparam int SEL_W     = `STRIPE_SEL_W;

  wr_state_e             state;
  logic [`STRIPE_ID_W-1:0] id_q;
  logic [    WORD_W-1:0] word_q;
  logic                  discard_q;
  len_t                  len_q;
  len_t                  beat_q;
  resp_e                 resp_q;

  logic [         SEL_W-1:0] bank_sel;
  logic [`STRIPE_BANK_AW-1:0] bank_addr;
  logic [     NUM_BANKS-1:0] req_vec;
  logic [     NUM_BANKS-1:0] ready_vec;
  logic                      aw_fire;
  logic                      w_fire;

  // Low word index bits pick the bank and the rest is the bank address
  assign bank_sel  = word_q[SEL_W-1:0];
  assign bank_addr = word_q[WORD_W-1:SEL_W];

  assign awready = (state == WR_IDLE);
  assign aw_fire = awvalid && awready;

  // A discarded burst sinks beats without touching any bank
  assign wready = (state == WR_DATA) && (discard_q || ready_vec[bank_sel]);
  assign w_fire = wvalid && wready;

  assign bvalid = (state == WR_RESP);
  assign bid    = id_q;
  assign bresp  = resp_q;

  for (genvar g = 0; g < NUM_BANKS; g++) begin : gen_bank_req
    assign req_vec[g] = (state == WR_DATA) && !discard_q && wvalid &&
                        (bank_sel == SEL_W'(g));

    assign wr_bank[g].req_valid = req_vec[g];
    assign wr_bank[g].req_write = 1'b1;
    assign wr_bank[g].req_addr  = bank_addr;
    assign wr_bank[g].req_data  = wdata;
    assign wr_bank[g].req_strb  = wstrb;
    assign ready_vec[g]         = wr_bank[g].req_ready;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= WR_IDLE;
      discard_q <= 1'b0;
      beat_q    <= '0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (aw_fire) begin
            discard_q <= (awburst != BURST_INCR) ||
                         (awsize != 3'(`STRIPE_FULL_SIZE));
            beat_q    <= '0;
            state     <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            beat_q <= beat_q + 8'd1;
            if (wlast) begin
              state <= WR_RESP;
            end
          end
        end
        WR_RESP: begin
          if (bready) begin
            state <= WR_IDLE;
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // Burst payload
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q   <= awid;
      word_q <= awaddr[ADDR_W-1 -: WORD_W];
      len_q  <= awlen;
    end else if (w_fire) begin
      word_q <= word_q + WORD_W'(1);
    end
    if (w_fire && wlast) begin
      resp_q <= discard_q ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // At most one bank takes a beat
  a_one_bank_req: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(ready_vec));

  // Host must close the burst on the beat that AWLEN promised
  a_wlast_on_len: assert property (@(posedge clk) disable iff (!rst_n)
    w_fire |-> (wlast == (beat_q == len_q)));

endmodule

/* logic/stripe_rd.sv */
`timescale 1ns/1ps

`include "stripe_defs.svh"

module stripe_rd (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      arvalid,
  output logic                      arready,
  input  logic [  `STRIPE_ID_W-1:0] arid,
  input  logic [`STRIPE_ADDR_W-1:0] araddr,

  output logic                      rvalid,
  input  logic                      rready,
  output logic [  `STRIPE_ID_W-1:0] rid,
  output logic [`STRIPE_DATA_W-1:0] rdata,
  output axi_pkg::resp_e            rresp,
  output logic                      rlast,

  bank_if.client                    rd_bank [`STRIPE_NUM_BANKS]
);
  import axi_pkg::*;
  import stripe_pkg::*;

  localparam int NUM_BANKS = `STRIPE_NUM_BANKS;
  localparam int ADDR_W    = `STRIPE_ADDR_W;
  localparam int WORD_W    = `STRIPE_WORD_W;
  localparam int SEL_W     = `STRIPE_SEL_W;

  rd_state_e                 state;
  logic [  `STRIPE_ID_W-1:0] id_q;
  logic [        WORD_W-1:0] word_q;
  logic [`STRIPE_DATA_W-1:0] data_q;

  logic [         SEL_W-1:0] bank_sel;
  logic [     NUM_BANKS-1:0] ready_vec;
  logic [     NUM_BANKS-1:0] rsp_vec;
  logic [`STRIPE_DATA_W-1:0] rsp_data_arr [NUM_BANKS];

  assign bank_sel = word_q[SEL_W-1:0];

  assign arready = (state == RD_IDLE);
  assign rvalid  = (state == RD_RESP);
  assign rid     = id_q;
  assign rdata   = data_q;
  assign rresp   = RESP_OKAY;
  assign rlast   = 1'b1;

  for (genvar g = 0; g < NUM_BANKS; g++) begin : gen_bank_req
    assign rd_bank[g].req_valid = (state == RD_REQ) && (bank_sel == SEL_W'(g));
    assign rd_bank[g].req_write = 1'b0;
    assign rd_bank[g].req_addr  = word_q[WORD_W-1:SEL_W];
    assign rd_bank[g].req_data  = '0;
    assign rd_bank[g].req_strb  = '0;
    assign ready_vec[g]         = rd_bank[g].req_ready;
    assign rsp_vec[g]           = rd_bank[g].rsp_valid;
    assign rsp_data_arr[g]      = rd_bank[g].rsp_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= RD_IDLE;
    end else begin
      case (state)
        RD_IDLE: if (arvalid) state <= RD_REQ;
        // Hold the request while the write engine owns the bank
        RD_REQ:  if (ready_vec[bank_sel]) state <= RD_WAIT;
        RD_WAIT: if (rsp_vec[bank_sel]) state <= RD_RESP;
        RD_RESP: if (rready) state <= RD_IDLE;
        default: state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      id_q   <= arid;
      word_q <= araddr[ADDR_W-1 -: WORD_W];
    end
    if (state == RD_WAIT && rsp_vec[bank_sel]) begin
      data_q <= rsp_data_arr[bank_sel];
    end
  end

  // Banks answer only the one read that is outstanding
  a_rsp_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
    (|rsp_vec) |-> (state == RD_WAIT));

endmodule

/* logic/bank_mem.sv */
`timescale 1ns/1ps

`include "stripe_defs.svh"

module bank_mem (
  input logic  clk,
  input logic  rst_n,
  bank_if.bank wr_port,
  bank_if.bank rd_port
);
  import stripe_pkg::*;

  localparam int DEPTH  = 2 ** `STRIPE_BANK_AW;
  localparam int DATA_W = `STRIPE_DATA_W;
  localparam int STRB_W = `STRIPE_STRB_W;

  logic [DATA_W-1:0] mem [DEPTH];

  client_e                    last_win;
  logic                       grant_wr;
  logic                       grant_rd;
  logic                       rsp_wr_q;
  logic                       rsp_rd_q;
  logic [DATA_W-1:0]          rdata_q;

  logic                       sel_write;
  logic [`STRIPE_BANK_AW-1:0] sel_addr;
  logic [DATA_W-1:0]          sel_data;
  logic [STRB_W-1:0]          sel_strb;

  // On a tie the client that lost last time goes first
  assign grant_wr = wr_port.req_valid &&
                    (!rd_port.req_valid || last_win == RD_CLIENT);
  assign grant_rd = rd_port.req_valid &&
                    (!wr_port.req_valid || last_win == WR_CLIENT);

  assign wr_port.req_ready = grant_wr;
  assign rd_port.req_ready = grant_rd;

  always_comb begin
    if (grant_rd) begin
      sel_write = rd_port.req_write;
      sel_addr  = rd_port.req_addr;
      sel_data  = rd_port.req_data;
      sel_strb  = rd_port.req_strb;
    end else begin
      sel_write = wr_port.req_write;
      sel_addr  = wr_port.req_addr;
      sel_data  = wr_port.req_data;
      sel_strb  = wr_port.req_strb;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_win <= RD_CLIENT;
      rsp_wr_q <= 1'b0;
      rsp_rd_q <= 1'b0;
    end else begin
      if (grant_wr) begin
        last_win <= WR_CLIENT;
      end else if (grant_rd) begin
        last_win <= RD_CLIENT;
      end
      rsp_wr_q <= grant_wr && !wr_port.req_write;
      rsp_rd_q <= grant_rd && !rd_port.req_write;
    end
  end

  always_ff @(posedge clk) begin
    if (grant_wr || grant_rd) begin
      if (sel_write) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (sel_strb[b]) begin
            mem[sel_addr][b*8 +: 8] <= sel_data[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem[sel_addr];
      end
    end
  end

  assign wr_port.rsp_valid = rsp_wr_q;
  assign wr_port.rsp_data  = rdata_q;
  assign rd_port.rsp_valid = rsp_rd_q;
  assign rd_port.rsp_data  = rdata_q;

  // A client that loses a tie wins the next cycle if it still asks
  a_rd_not_starved: assert property (@(posedge clk) disable iff (!rst_n)
    (grant_wr && rd_port.req_valid) |=> (grant_rd || !rd_port.req_valid));

  a_wr_not_starved: assert property (@(posedge clk) disable iff (!rst_n)
    (grant_rd && wr_port.req_valid) |=> (grant_wr || !wr_port.req_valid));

endmodule

/* logic/stripe_top.sv */
`timescale 1ns/1ps

`include "stripe_defs.svh"

module stripe_top (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      awvalid,
  output logic                      awready,
  input  logic [  `STRIPE_ID_W-1:0] awid,
  input  logic [`STRIPE_ADDR_W-1:0] awaddr,
  input  logic [               7:0] awlen,
  input  logic [               2:0] awsize,
  input  logic [               1:0] awburst,

  input  logic                      wvalid,
  output logic                      wready,
  input  logic [`STRIPE_DATA_W-1:0] wdata,
  input  logic [`STRIPE_STRB_W-1:0] wstrb,
  input  logic                      wlast,

  output logic                      bvalid,
  input  logic                      bready,
  output logic [  `STRIPE_ID_W-1:0] bid,
  output logic [               1:0] bresp,

  input  logic                      arvalid,
  output logic                      arready,
  input  logic [  `STRIPE_ID_W-1:0] arid,
  input  logic [`STRIPE_ADDR_W-1:0] araddr,

  output logic                      rvalid,
  input  logic                      rready,
  output logic [  `STRIPE_ID_W-1:0] rid,
  output logic [`STRIPE_DATA_W-1:0] rdata,
  output logic [               1:0] rresp,
  output logic                      rlast
);
  import axi_pkg::*;

  // One link per bank for each engine
  bank_if wr_bus [`STRIPE_NUM_BANKS] ();
  bank_if rd_bus [`STRIPE_NUM_BANKS] ();

  stripe_wr i_wr (
    .clk     (clk),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awready (awready),
    .awid    (awid),
    .awaddr  (awaddr),
    .awlen   (awlen),
    .awsize  (awsize),
    .awburst (burst_e'(awburst)),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .bvalid  (bvalid),
    .bready  (bready),
    .bid     (bid),
    .bresp   (bresp),
    .wr_bank (wr_bus)
  );

  stripe_rd i_rd (
    .clk     (clk),
    .rst_n   (rst_n),
    .arvalid (arvalid),
    .arready (arready),
    .arid    (arid),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rid     (rid),
    .rdata   (rdata),
    .rresp   (rresp),
    .rlast   (rlast),
    .rd_bank (rd_bus)
  );

  for (genvar i = 0; i < `STRIPE_NUM_BANKS; i++) begin : gen_bank
    bank_mem i_bank (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_port (wr_bus[i]),
      .rd_port (rd_bus[i])
    );
  end

endmodule

/* verif/stripe_tb.sv */
`timescale 1ns/1ps

`include "stripe_defs.svh"

module stripe_tb;
  import axi_pkg::*;

  // Tests take about 1500 cycles
  localparam int MAX_CYCLES = 4000;
  localparam int NUM_WORDS  = 2 ** `STRIPE_WORD_W;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      awvalid, awready, wvalid, wready, wlast;
  logic                      bvalid, bready, arvalid, arready;
  logic                      rvalid, rready, rlast;
  logic [  `STRIPE_ID_W-1:0] awid, bid, arid, rid;
  logic [`STRIPE_ADDR_W-1:0] awaddr, araddr;
  logic [               7:0] awlen;
  logic [               2:0] awsize;
  logic [               1:0] awburst, bresp, rresp;
  logic [`STRIPE_DATA_W-1:0] wdata, rdata;
  logic [`STRIPE_STRB_W-1:0] wstrb;

  // Byte-level reference of the whole host space
  logic [7:0]                ref_mem [2 ** `STRIPE_ADDR_W];
  logic [  `STRIPE_ID_W-1:0] exp_bid = '0;
  logic [  `STRIPE_ID_W-1:0] exp_rid = '0;
  logic [               1:0] exp_bresp = '0;
  logic [`STRIPE_DATA_W-1:0] exp_rdata = '0;

  integer seed;
  int     errors = 0;
  int     writes = 0;
  int     reads  = 0;
  int     cycles = 0;

  stripe_top i_dut (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    errors++;
    $display("ERROR %0t: %s expected %h, got %h", $time, sig, exp_v, act_v);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("ERROR %0t: %s", $time, what);
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  a_reset_idle: assert property (@(posedge clk)
    $rose(rst_n) |-> (!bvalid && !rvalid && !wready && awready && arready))
    else report_failure("channel handshakes not idle after reset");
  a_bid: assert property (@(posedge clk) disable iff (!rst_n) bvalid |-> bid == exp_bid)
    else report_mismatch("bid", 32'(exp_bid), 32'($sampled(bid)));
  a_bresp: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid |-> bresp == exp_bresp)
    else report_mismatch("bresp", 32'(exp_bresp), 32'($sampled(bresp)));
  a_b_after_wlast: assert property (@(posedge clk) disable iff (!rst_n)
    (wvalid && wready && wlast) |=> bvalid)
    else report_failure("bvalid did not rise one cycle after the last beat");
  a_b_only_after_wlast: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(bvalid) |-> $past(wvalid && wready && wlast))
    else report_failure("bvalid rose without a last beat in the cycle before");
  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (bvalid && !bready) |=> (bvalid && $stable(bid) && $stable(bresp)))
    else report_failure("write response dropped or changed while stalled");
  a_no_aw_in_b: assert property (@(posedge clk) disable iff (!rst_n) bvalid |-> !awready)
    else report_failure("new write address accepted before the response");
  a_rid: assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> rid == exp_rid)
    else report_mismatch("rid", 32'(exp_rid), 32'($sampled(rid)));
  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid |-> rdata == exp_rdata)
    else report_mismatch("rdata", 32'(exp_rdata), 32'($sampled(rdata)));
  a_rresp: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid |-> rresp == RESP_OKAY)
    else report_mismatch("rresp", 32'(RESP_OKAY), 32'($sampled(rresp)));
  a_rlast: assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> rlast)
    else report_mismatch("rlast", 32'd1, 32'($sampled(rlast)));
  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (rvalid && !rready) |=> (rvalid && $stable(rid) && $stable(rdata)))
    else report_failure("read data dropped or changed while stalled");
  a_no_ar_in_r: assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> !arready)
    else report_failure("new read address accepted before the read data");

  // Handshakes are checked 1 ns after the falling edge, where ready is settled
  task automatic write_burst(input int word, input int len, input logic [2:0] size,
                             input logic [1:0] burst, input bit part_strb,
                             input int stall);
    logic [`STRIPE_ID_W-1:0] id;
    bit                      ok;
    id = `STRIPE_ID_W'($random(seed));
    ok = (burst == BURST_INCR) && (size == 3'(`STRIPE_FULL_SIZE));
    @(negedge clk);
    awvalid = 1'b1;
    awid    = id;
    awaddr  = `STRIPE_ADDR_W'(word * `STRIPE_STRB_W);
    awlen   = 8'(len - 1);
    awsize  = size;
    awburst = burst;
    #1;
    while (!awready) begin
      @(negedge clk);
      #1;
    end
    exp_bid   = id;
    exp_bresp = ok ? RESP_OKAY : RESP_SLVERR;
    @(negedge clk);
    awvalid = 1'b0;
    for (int i = 0; i < len; i++) begin
      wvalid = 1'b1;
      wdata  = `STRIPE_DATA_W'($random(seed));
      wstrb  = part_strb ? `STRIPE_STRB_W'($random(seed)) : '1;
      wlast  = (i == len - 1);
      #1;
      while (!wready) begin
        @(negedge clk);
        #1;
      end
      for (int b = 0; b < `STRIPE_STRB_W; b++) begin
        if (ok && wstrb[b]) begin
          ref_mem[`STRIPE_ADDR_W'((word + i) * `STRIPE_STRB_W + b)] = wdata[b*8 +: 8];
        end
      end
      @(negedge clk);
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    repeat (stall) @(negedge clk);
    bready = 1'b1;
    #1;
    while (!bvalid) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    bready = 1'b0;
    writes++;
  endtask

  task automatic read_word(input int word, input int stall);
    logic [`STRIPE_ID_W-1:0] id;
    id = `STRIPE_ID_W'($random(seed));
    @(negedge clk);
    arvalid = 1'b1;
    arid    = id;
    araddr  = `STRIPE_ADDR_W'(word * `STRIPE_STRB_W);
    #1;
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    exp_rid   = id;
    exp_rdata = {ref_mem[`STRIPE_ADDR_W'(word * 2 + 1)], ref_mem[`STRIPE_ADDR_W'(word * 2)]};
    @(negedge clk);
    arvalid = 1'b0;
    repeat (stall) @(negedge clk);
    rready = 1'b1;
    #1;
    while (!rvalid) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    rready = 1'b0;
    reads++;
  endtask

  initial begin : stimulus
    int len;
    int word;
    seed    = 32'hcb73d5bf;
    rst_n   = 1'b0;
    awvalid = 1'b0;
    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    awsize  = '0;
    awburst = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    bready  = 1'b0;
    arvalid = 1'b0;
    arid    = '0;
    araddr  = '0;
    rready  = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // Fill every word so that all later reads are defined
    for (int w = 0; w < NUM_WORDS; w += 8) begin
      write_burst(w, 8, 3'(`STRIPE_FULL_SIZE), BURST_INCR, 1'b0, 0);
    end
    repeat (20) begin
      len  = 1 + rand_below(8);
      word = rand_below(NUM_WORDS + 1 - len);
      write_burst(word, len, 3'(`STRIPE_FULL_SIZE), BURST_INCR, 1'b0, rand_below(4));
    end
    for (int w = 0; w < NUM_WORDS; w++) begin
      read_word(w, rand_below(3));
    end

    // Partial strobes
    repeat (6) begin
      len  = 1 + rand_below(4);
      word = rand_below(NUM_WORDS + 1 - len);
      write_burst(word, len, 3'(`STRIPE_FULL_SIZE), BURST_INCR, 1'b1, 0);
      for (int i = 0; i < len; i++) begin
        read_word(word + i, 0);
      end
    end

    // FIXED, WRAP and a narrow size are all refused
    write_burst(10, 4, 3'(`STRIPE_FULL_SIZE), BURST_FIXED, 1'b0, 1);
    write_burst(20, 4, 3'(`STRIPE_FULL_SIZE), BURST_WRAP, 1'b0, 0);
    write_burst(30, 4, 3'd0, BURST_INCR, 1'b0, 2);
    for (int i = 0; i < 4; i++) begin
      read_word(10 + i, 0);
      read_word(20 + i, 0);
      read_word(30 + i, 0);
    end

    // Reads from the upper half contend with bursts to the lower half
    repeat (8) begin
      word = rand_below(NUM_WORDS / 2 - 7);
      fork
        write_burst(word, 8, 3'(`STRIPE_FULL_SIZE), BURST_INCR, 1'b1, rand_below(3));
        begin
          repeat (2) @(negedge clk);
          read_word(NUM_WORDS / 2 + rand_below(NUM_WORDS / 2), 0);
          read_word(NUM_WORDS / 2 + rand_below(NUM_WORDS / 2), rand_below(3));
        end
      join
    end

    repeat (4) @(negedge clk);
    $display("Summary: %0d write bursts, %0d reads, %0d errors", writes, reads, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+logic
logic/axi_pkg.sv
logic/stripe_pkg.sv
logic/bank_if.sv
logic/stripe_wr.sv
logic/stripe_rd.sv
logic/bank_mem.sv
logic/stripe_top.sv
verif/stripe_tb.sv

/* build.sh */
#!/usr/bin/env bash
# Compile and run the stripe testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -f build.f --top-module stripe_tb -o stripe_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/stripe_sim > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG"
if grep -q "FAIL: see errors above" "$LOG"; then
  exit 1
fi
exit 0
